// File: c2fAgeOrder.sv
// Age tracker for the core-to-fabric buffer
// Age matrix updated on allocation,
// oldest entry lookup for the send and ready classes
`timescale 1ns/1ps
`default_nettype none

module c2fAgeOrder
    import c2fPkg::*;
(
    input  logic                   QClk,
    input  logic                   reset,
    input  logic [C2fEntries-1:0]  allocVec,
    input  logic [C2fEntries-1:0]  freeVec,
    input  logic [C2fEntries-1:0]  sendMask,
    input  logic [C2fEntries-1:0]  readyMask,
    output logic [C2fIdxWidth-1:0] sendIdx,
    output logic [C2fIdxWidth-1:0] readyIdx,
    output logic                   sendFound,
    output logic                   readyFound
);

    logic [C2fEntries-1:0]                 occupied;
    logic [C2fEntries-1:0][C2fEntries-1:0] older;    // older[j][i]: j allocated before i

    // Entry in the mask with no older masked entry
    function automatic logic [C2fIdxWidth-1:0] oldestOf(
        input logic [C2fEntries-1:0]                 mask,
        input logic [C2fEntries-1:0][C2fEntries-1:0] ageMat
    );
        logic [C2fIdxWidth-1:0] idx;
        logic                   blocked;
        idx = '0;
        for (int i = 0; i < C2fEntries; i++) begin
            blocked = 1'b0;
            for (int j = 0; j < C2fEntries; j++) begin
                if (mask[j] && ageMat[j][i]) blocked = 1'b1;
            end
            if (mask[i] && !blocked) idx = C2fIdxWidth'(i);
        end
        return idx;
    endfunction

    always_ff @(posedge QClk) begin
        if (reset) begin
            occupied <= '0;
            older    <= '0;
        end else begin
            occupied <= (occupied | allocVec) & ~freeVec;
            for (int k = 0; k < C2fEntries; k++) begin
                if (allocVec[k]) begin                    // New entry is the youngest
                    for (int j = 0; j < C2fEntries; j++) begin
                        older[j][k] <= occupied[j] && (j != k);
                        older[k][j] <= 1'b0;
                    end
                end
            end
        end
    end

    assign sendIdx    = oldestOf(sendMask, older);
    assign readyIdx   = oldestOf(readyMask, older);
    assign sendFound  = |sendMask;
    assign readyFound = |readyMask;

endmodule

`default_nettype wire

// File: c2fBuffer.sv
// Core-to-fabric buffer
// Request acceptance, per-entry state machines,
// read response capture, registered core response, stall
`timescale 1ns/1ps
`default_nettype none

module c2fBuffer
    import ringPkg::*;
    import c2fPkg::*;
(
    input  logic                   QClk,
    input  logic                   reset,
    input  logic [CoreIdWidth-1:0] coreId,
    input  coreReqT                coreReq,
    input  ringPacketT             ringInQ501,
    output logic                   respHit,
    output ringPacketT             sendReq,
    input  logic                   localSent,
    output coreRspT                coreRsp,
    output logic                   stall,
    output logic [C2fEntries-1:0]  allocVec,
    output logic [C2fEntries-1:0]  freeVec,
    output logic [C2fEntries-1:0]  sendMask,
    output logic [C2fEntries-1:0]  readyMask,
    input  logic [C2fIdxWidth-1:0] sendIdx,
    input  logic [C2fIdxWidth-1:0] readyIdx,
    input  logic                   sendFound,
    input  logic                   readyFound
);

    entryStateT            state     [C2fEntries];
    entryStateT            stateNext [C2fEntries];
    coreReqT               entry     [C2fEntries];   // Request payload, data reused for the response
    logic [C2fEntries-1:0] freeMask;
    logic [C2fEntries-1:0] matchVec;
    logic [C2fEntries-1:0] matchFirst;
    logic                  legalReq;
    logic                  deliver;

    // Lowest set bit, one-hot
    function automatic logic [C2fEntries-1:0] firstOne(input logic [C2fEntries-1:0] vec);
        return vec & (~vec + 1'b1);
    endfunction

    // ====================
    // Acceptance and match
    // ====================
    always_comb begin
        for (int i = 0; i < C2fEntries; i++) begin
            freeMask[i]  = (state[i] == FREE);
            sendMask[i]  = (state[i] == SEND_WRITE) || (state[i] == SEND_READ);
            readyMask[i] = (state[i] == READ_READY);
            matchVec[i]  = ringInQ501.valid && (ringInQ501.opcode == RD_RSP)
                           && (state[i] == READ_WAIT)
                           && (entry[i].address == ringInQ501.address);
        end
    end

    assign stall      = ~|freeMask;                  // No FREE entry left
    assign legalReq   = coreReq.valid && !stall
                        && ((coreReq.opcode == RD) || (coreReq.opcode == WR))
                        && (coreReq.address[CoreIdMsb:CoreIdLsb] != coreId);
    assign allocVec   = legalReq ? firstOne(freeMask) : '0;
    assign matchFirst = firstOne(matchVec);           // One entry per response
    assign respHit    = |matchVec;                    // Response consumed, not forwarded

    // Same thread is not answered two cycles running
    assign deliver = readyFound
                     && !(coreRsp.valid && (coreRsp.threadId == entry[readyIdx].threadId));

    // Oldest pending request toward the arbiter
    always_comb begin
        sendReq.valid   = sendFound;
        sendReq.address = entry[sendIdx].address;
        sendReq.data    = entry[sendIdx].data;
        if (state[sendIdx] == SEND_WRITE) begin
            sendReq.opcode = WR;
        end else begin
            sendReq.opcode = RD;
        end
    end

    // ====================
    // Entry state machines
    // ====================
    always_comb begin
        for (int i = 0; i < C2fEntries; i++) begin
            stateNext[i] = state[i];
            case (state[i])
                FREE: begin
                    if (allocVec[i]) begin
                        stateNext[i] = (coreReq.opcode == WR) ? SEND_WRITE : SEND_READ;
                    end
                end
                SEND_WRITE: begin
                    if (localSent && (sendIdx == C2fIdxWidth'(i))) stateNext[i] = FREE;
                end
                SEND_READ: begin
                    if (localSent && (sendIdx == C2fIdxWidth'(i))) stateNext[i] = READ_WAIT;
                end
                READ_WAIT: begin
                    if (matchFirst[i]) stateNext[i] = READ_READY;
                end
                READ_READY: begin
                    if (deliver && (readyIdx == C2fIdxWidth'(i))) stateNext[i] = FREE;
                end
                default: stateNext[i] = FREE;
            endcase
            freeVec[i] = (state[i] != FREE) && (stateNext[i] == FREE);   // Release to age tracker
        end
    end

    always_ff @(posedge QClk) begin
        if (reset) begin
            for (int i = 0; i < C2fEntries; i++) begin
                state[i] <= FREE;
            end
            coreRsp.valid <= 1'b0;
        end else begin
            for (int i = 0; i < C2fEntries; i++) begin
                state[i] <= stateNext[i];
            end
            coreRsp.valid    <= deliver;
            coreRsp.threadId <= entry[readyIdx].threadId;
            coreRsp.data     <= entry[readyIdx].data;
        end
    end

    // Payload, written on allocation or response capture
    always_ff @(posedge QClk) begin
        for (int i = 0; i < C2fEntries; i++) begin
            if (allocVec[i]) begin
                entry[i] <= coreReq;
            end else if (matchFirst[i]) begin
                entry[i].data <= ringInQ501.data;
            end
        end
    end

endmodule

`default_nettype wire

// File: c2fPkg.sv
// Core-to-fabric buffer definitions
// Depth, thread id width, ventilation limit,
// entry states, core request and response words, ring output select
`default_nettype none

package c2fPkg;

    localparam int C2fEntries    = 4;
    localparam int C2fIdxWidth   = $clog2(C2fEntries);
    localparam int ThreadIdWidth = 2;
    localparam int VentLimit     = 3;                      // Local inserts before a forced gap
    localparam int VentCntWidth  = $clog2(VentLimit + 1);

    // Per-entry life cycle
    typedef enum logic [2:0] {
        FREE,
        SEND_WRITE,     // Waiting for a ring slot
        SEND_READ,
        READ_WAIT,      // On the ring, response pending
        READ_READY      // Response captured, core not told yet
    } entryStateT;

    // Core request, opcode uses the ring encoding
    typedef struct packed {
        logic                     valid;
        logic [1:0]               opcode;
        logic [ThreadIdWidth-1:0] threadId;
        logic [31:0]              address;
        logic [31:0]              data;
    } coreReqT;

    typedef struct packed {
        logic                     valid;
        logic [ThreadIdWidth-1:0] threadId;
        logic [31:0]              data;
    } coreRspT;

    // Source of the next ring output slot
    typedef enum logic [1:0] {SEL_NOP, SEL_RING, SEL_LOCAL} ringSelT;

endpackage

`default_nettype wire

// File: rc.sv
// Ring controller top level
// Connects the ring arbiter, the core-to-fabric buffer
// and its age tracker
`timescale 1ns/1ps
`default_nettype none

module rc
    import ringPkg::*;
    import c2fPkg::*;
(
    input  logic                   QClk,
    input  logic                   reset,
    input  logic [CoreIdWidth-1:0] coreId,
    input  ringPacketT             ringIn,
    output ringPacketT             ringOut,
    input  coreReqT                coreReq,
    output coreRspT                coreRsp,
    output logic                   stall
);

    // ====================
    // Internal nets
    // ====================
    ringPacketT             ringInQ501;         // Sampled ring input
    ringPacketT             sendReq;            // Oldest local request
    logic                   respHit;
    logic                   localSent;
    logic [C2fEntries-1:0]  allocVec;
    logic [C2fEntries-1:0]  freeVec;
    logic [C2fEntries-1:0]  sendMask;
    logic [C2fEntries-1:0]  readyMask;
    logic [C2fIdxWidth-1:0] sendIdx;
    logic [C2fIdxWidth-1:0] readyIdx;
    logic                   sendFound;
    logic                   readyFound;

    ringArbiter iArbiter (
        .QClk       (QClk),
        .reset      (reset),
        .ringIn     (ringIn),
        .ringInQ501 (ringInQ501),
        .respHit    (respHit),
        .sendReq    (sendReq),
        .localSent  (localSent),
        .ringOut    (ringOut)
    );

    c2fBuffer iBuffer (
        .QClk       (QClk),
        .reset      (reset),
        .coreId     (coreId),
        .coreReq    (coreReq),
        .ringInQ501 (ringInQ501),
        .respHit    (respHit),
        .sendReq    (sendReq),
        .localSent  (localSent),
        .coreRsp    (coreRsp),
        .stall      (stall),
        .allocVec   (allocVec),
        .freeVec    (freeVec),
        .sendMask   (sendMask),
        .readyMask  (readyMask),
        .sendIdx    (sendIdx),
        .readyIdx   (readyIdx),
        .sendFound  (sendFound),
        .readyFound (readyFound)
    );

    c2fAgeOrder iAgeOrder (
        .QClk       (QClk),
        .reset      (reset),
        .allocVec   (allocVec),
        .freeVec    (freeVec),
        .sendMask   (sendMask),
        .readyMask  (readyMask),
        .sendIdx    (sendIdx),
        .readyIdx   (readyIdx),
        .sendFound  (sendFound),
        .readyFound (readyFound)
    );

endmodule

`default_nettype wire

// File: rcMonitor.sv
// Ring controller monitor
// Reference model of pending requests, ring pass-through
// and ventilation, compares DUT ports and counts errors
`timescale 1ns/1ps
`default_nettype none

module rcMonitor
    import ringPkg::*;
    import c2fPkg::*;
(
    input  logic       QClk,
    input  logic       reset,
    input  logic [7:0] coreId,
    input  ringPacketT ringIn,
    input  ringPacketT ringOut,
    input  coreReqT    coreReq,
    input  coreRspT    coreRsp,
    input  logic       stall,
    output int         ringErrors,
    output int         coreErrors,
    output logic       drained
);

    ringPacketT  sendQ[$];         // Accepted, not yet on the ring
    logic [1:0]  sendThr[$];
    logic [31:0] waitAddr[$];      // Reads on the ring, no response yet
    logic [1:0]  waitThr[$];
    logic [1:0]  rspThr[$];        // Responses owed to the core
    logic [31:0] rspData[$];
    ringPacketT  pipe[2];          // ringIn delayed by one and two cycles
    logic        pipeUsed[2];      // Consumed as a read response
    int          occ;
    int          vent;

    assign drained = (sendQ.size() == 0) && (waitAddr.size() == 0) && (rspThr.size() == 0);

    always @(posedge QClk) begin
        ringPacketT exp;
        logic       expValid;
        logic       used;
        if (reset) begin
            sendQ.delete();
            sendThr.delete();
            waitAddr.delete();
            waitThr.delete();
            rspThr.delete();
            rspData.delete();
            pipe[0] = '0;
            pipe[1] = '0;
            pipeUsed[0] = 1'b0;
            pipeUsed[1] = 1'b0;
            occ = 0;
            vent = 0;
            ringErrors <= 0;
            coreErrors <= 0;
        end else begin
            exp      = pipe[1];
            expValid = pipe[1].valid && !pipeUsed[1];
            // ====================
            // Ring output
            // ====================
            if (ringOut.valid) begin
                if (vent == VentLimit) begin
                    $display("FAILED at %0t: ringOut valid in a forced empty slot", $time);
                    ringErrors <= ringErrors + 1;
                end
                if (expValid) begin
                    if (ringOut != exp) begin
                        $display("FAILED at %0t: ringOut expected %h got %h",
                                 $time, exp, ringOut);
                        ringErrors <= ringErrors + 1;
                    end
                end else if (sendQ.size() == 0) begin
                    $display("FAILED at %0t: ringOut carries an unexpected packet %h",
                             $time, ringOut);
                    ringErrors <= ringErrors + 1;
                end else begin
                    if (ringOut != sendQ[0]) begin
                        $display("FAILED at %0t: ringOut expected %h got %h",
                                 $time, sendQ[0], ringOut);
                        ringErrors <= ringErrors + 1;
                    end
                    if (sendQ[0].opcode == RD) begin
                        waitAddr.push_back(sendQ[0].address);
                        waitThr.push_back(sendThr[0]);
                    end else begin
                        occ = occ - 1;                  // Write entry freed when sent
                    end
                    void'(sendQ.pop_front());
                    void'(sendThr.pop_front());
                    vent = vent + 1;
                end
            end else begin
                if (expValid && vent != VentLimit) begin
                    $display("FAILED at %0t: ringOut expected %h got an empty slot",
                             $time, exp);
                    ringErrors <= ringErrors + 1;
                end
                vent = 0;
            end
            // Core response
            if (coreRsp.valid) begin
                if (rspThr.size() == 0) begin
                    $display("FAILED at %0t: coreRsp valid with no response owed", $time);
                    coreErrors <= coreErrors + 1;
                end else begin
                    if (coreRsp.threadId != rspThr[0] || coreRsp.data != rspData[0]) begin
                        $display("FAILED at %0t: coreRsp expected thr %0d data %h got thr %0d data %h",
                                 $time, rspThr[0], rspData[0], coreRsp.threadId, coreRsp.data);
                        coreErrors <= coreErrors + 1;
                    end
                    void'(rspThr.pop_front());
                    void'(rspData.pop_front());
                    occ = occ - 1;
                end
            end
            if (stall != (occ == C2fEntries)) begin
                $display("FAILED at %0t: stall expected %0b got %0b",
                         $time, (occ == C2fEntries), stall);
                coreErrors <= coreErrors + 1;
            end
            // ====================
            // Core request and ring input
            // ====================
            if (coreReq.valid && occ < C2fEntries
                && (coreReq.opcode == RD || coreReq.opcode == WR)
                && coreReq.address[31:24] != coreId) begin
                sendQ.push_back(makeSent(coreReq));
                sendThr.push_back(coreReq.threadId);
                occ = occ + 1;
            end
            used = 1'b0;
            if (ringIn.valid && ringIn.opcode == RD_RSP) begin
                for (int i = 0; i < waitAddr.size(); i++) begin
                    if (!used && waitAddr[i] == ringIn.address) begin
                        rspThr.push_back(waitThr[i]);
                        rspData.push_back(ringIn.data);
                        waitAddr.delete(i);
                        waitThr.delete(i);
                        used = 1'b1;
                    end
                end
            end
            pipe[1]     = pipe[0];
            pipeUsed[1] = pipeUsed[0];
            pipe[0]     = ringIn;
            pipeUsed[0] = used;
        end
    end

    function automatic ringPacketT makeSent(input coreReqT req);
        ringPacketT p;
        p.valid   = 1'b1;
        p.opcode  = opcodeT'(req.opcode);
        p.address = req.address;
        p.data    = req.data;
        return p;
    endfunction

endmodule

`default_nettype wire

// File: rc_checker.sv
// Concurrent assertions on the ring controller
// Stall against occupancy, ventilation, response spacing, reset values
`timescale 1ns/1ps
`default_nettype none

module rc_checker
    import ringPkg::*;
    import c2fPkg::*;
(
    input logic                  QClk,
    input logic                  reset,
    input logic                  stall,
    input logic                  localSent,
    input logic [C2fEntries-1:0] allocVec,
    input logic [C2fEntries-1:0] freeVec,
    input ringPacketT            ringOut,
    input coreRspT               coreRsp
);

    logic [C2fEntries-1:0] occupied;   // Entries not FREE

    always_ff @(posedge QClk) begin
        if (reset) begin
            occupied <= '0;
        end else begin
            occupied <= (occupied | allocVec) & ~freeVec;
        end
    end

    stallFull: assert property (@(posedge QClk) disable iff (reset) stall |-> &occupied)
        else $error("stall high while an entry is free");

    // At most three local inserts in a row
    ventGap: assert property (@(posedge QClk) disable iff (reset)
        !(localSent && $past(localSent) && $past(localSent, 2) && $past(localSent, 3)))
        else $error("more than three consecutive local slots");

    rspSpacing: assert property (@(posedge QClk) disable iff (reset)
        (coreRsp.valid && $past(coreRsp.valid)) |-> coreRsp.threadId != $past(coreRsp.threadId))
        else $error("same thread answered two cycles running");

    resetLow: assert property (@(posedge QClk)
        $past(reset) |-> (!ringOut.valid && !coreRsp.valid && !stall))
        else $error("outputs not low after reset");

endmodule

bind rc rc_checker iChecker (
    .QClk      (QClk),
    .reset     (reset),
    .stall     (stall),
    .localSent (localSent),
    .allocVec  (allocVec),
    .freeVec   (freeVec),
    .ringOut   (ringOut),
    .coreRsp   (coreRsp)
);

`default_nettype wire

// File: ringArbiter.sv
// Ring output arbiter
// Ring input sample, output source selection,
// ventilation counter and the ring output register
`timescale 1ns/1ps
`default_nettype none

module ringArbiter
    import ringPkg::*;
    import c2fPkg::*;
(
    input  logic       QClk,
    input  logic       reset,
    input  ringPacketT ringIn,
    output ringPacketT ringInQ501,
    input  logic       respHit,
    input  ringPacketT sendReq,
    output logic       localSent,
    output ringPacketT ringOut
);

    ringSelT                 sel;
    ringPacketT              nextOut;
    logic [VentCntWidth-1:0] ventCnt;      // Consecutive local inserts

    // ====================
    // Slot selection
    // ====================
    always_comb begin
        if (ventCnt == VentCntWidth'(VentLimit)) begin
            sel = SEL_NOP;                              // Forced gap, ring packet dropped
        end else if (ringInQ501.valid && !respHit) begin
            sel = SEL_RING;                             // Pass-through traffic first
        end else if (sendReq.valid) begin
            sel = SEL_LOCAL;
        end else begin
            sel = SEL_NOP;
        end
    end

    always_comb begin
        case (sel)
            SEL_RING:  nextOut = ringInQ501;
            SEL_LOCAL: nextOut = sendReq;
            default:   nextOut = '0;                     // Empty slot
        endcase
    end

    assign localSent = (sel == SEL_LOCAL);

    // ====================
    // Registers
    // ====================
    always_ff @(posedge QClk) begin
        if (reset) begin
            ringInQ501.valid <= 1'b0;
            ringOut.valid    <= 1'b0;
            ventCnt          <= '0;
        end else begin
            ringInQ501 <= ringIn;                       // First stage
            ringOut    <= nextOut;                      // Second stage
            if (!nextOut.valid) begin
                ventCnt <= '0;                          // Any empty slot ventilates
            end else if (localSent) begin
                ventCnt <= ventCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: ringPkg.sv
// Ring-level definitions
// Opcode encoding on the ring, the ring word struct
// and the address field holding the target core id
`default_nettype none

package ringPkg;

    // ====================
    // Field widths
    // ====================
    localparam int AddrWidth   = 32;
    localparam int DataWidth   = 32;
    localparam int CoreIdMsb   = 31;           // Target core id lives in the top byte
    localparam int CoreIdLsb   = 24;
    localparam int CoreIdWidth = CoreIdMsb - CoreIdLsb + 1;

    // Ring opcodes, encoding as seen on the wire
    typedef enum logic [1:0] {
        RD       = 2'b00,
        RD_RSP   = 2'b01,
        WR       = 2'b10,
        WR_BCAST = 2'b11                       // Not served here, only rejected
    } opcodeT;

    // One ring slot, valid low means empty slot
    typedef struct packed {
        logic                 valid;
        opcodeT               opcode;
        logic [AddrWidth-1:0] address;
        logic [DataWidth-1:0] data;
    } ringPacketT;

endpackage

`default_nettype wire

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the ring controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tbRc \
    -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
    exit 0
else
    exit 1
fi

// File: sources.f
ringPkg.sv
c2fPkg.sv
ringArbiter.sv
c2fAgeOrder.sv
c2fBuffer.sv
rc.sv
rc_checker.sv
rcMonitor.sv
tbRc.sv

// File: tbRc.sv
// Testbench top for the ring controller
// Clock, reset, stimulus table applied in a loop,
// cycle limit and the closing report
`timescale 1ns/1ps
`default_nettype none

module tbRc
    import ringPkg::*;
    import c2fPkg::*;
;

    logic             QClk;
    logic             reset;
    logic [7:0]       coreId;
    ringPacketT       ringIn;
    ringPacketT       ringOut;
    coreReqT          coreReq;
    coreRspT          coreRsp;
    logic             stall;
    int               ringErrors;
    int               coreErrors;
    logic             drained;
    int               cycles;
    int               cycleLimit;
    int               seed;

    // ====================
    // Stimulus table
    // ====================
    ringPacketT tabRing[$];
    coreReqT    tabReq[$];
    int         tabIdle[$];

    rc i_rc (
        .QClk    (QClk),
        .reset   (reset),
        .coreId  (coreId),
        .ringIn  (ringIn),
        .ringOut (ringOut),
        .coreReq (coreReq),
        .coreRsp (coreRsp),
        .stall   (stall)
    );

    rcMonitor iMonitor (
        .QClk       (QClk),
        .reset      (reset),
        .coreId     (coreId),
        .ringIn     (ringIn),
        .ringOut    (ringOut),
        .coreReq    (coreReq),
        .coreRsp    (coreRsp),
        .stall      (stall),
        .ringErrors (ringErrors),
        .coreErrors (coreErrors),
        .drained    (drained)
    );

    function automatic ringPacketT makePkt(input opcodeT op, input logic [31:0] addr,
                                           input logic [31:0] data);
        ringPacketT p;
        p.valid   = 1'b1;
        p.opcode  = op;
        p.address = addr;
        p.data    = data;
        return p;
    endfunction

    function automatic coreReqT makeReq(input logic [1:0] op, input logic [1:0] thr,
                                        input logic [31:0] addr, input logic [31:0] data);
        coreReqT r;
        r.valid    = 1'b1;
        r.opcode   = op;
        r.threadId = thr;
        r.address  = addr;
        r.data     = data;
        return r;
    endfunction

    task automatic addRow(input ringPacketT pkt, input coreReqT req, input int idle);
        tabRing.push_back(pkt);
        tabReq.push_back(req);
        tabIdle.push_back(idle);
    endtask

    // Fixed-seed data words
    function automatic logic [31:0] rndWord();
        return $random(seed);
    endfunction

    task automatic buildTable();
        // Forwarding with an empty buffer
        addRow(makePkt(WR, 32'h3300_0010, rndWord()), '0, 0);
        addRow(makePkt(RD, 32'h4400_0020, rndWord()), '0, 1);
        addRow(makePkt(RD_RSP, 32'h3300_0030, rndWord()), '0, 3);
        // Writes in acceptance order
        addRow('0, makeReq(WR, 2'd0, 32'h5A00_0000, rndWord()), 0);
        addRow('0, makeReq(WR, 2'd1, 32'h5A00_0004, rndWord()), 0);
        addRow(makePkt(WR, 32'h3300_0040, rndWord()), makeReq(WR, 2'd2, 32'h5A00_0008,
               rndWord()), 5);
        // Read round trip, then an unmatched response
        addRow('0, makeReq(RD, 2'd1, 32'h5A00_0100, rndWord()), 6);
        addRow(makePkt(RD_RSP, 32'h5A00_0100, 32'hCAFE_0001), '0, 6);
        addRow(makePkt(RD_RSP, 32'h5A00_0999, 32'hCAFE_0002), '0, 4);
        // Four reads fill the buffer, the fifth request is dropped
        addRow('0, makeReq(RD, 2'd0, 32'h5A00_0200, rndWord()), 0);
        addRow('0, makeReq(RD, 2'd1, 32'h5A00_0210, rndWord()), 0);
        addRow('0, makeReq(RD, 2'd2, 32'h5A00_0220, rndWord()), 0);
        addRow('0, makeReq(RD, 2'd1, 32'h5A00_0230, rndWord()), 8);
        addRow('0, makeReq(WR, 2'd0, 32'h5A00_0300, rndWord()), 2);
        // Thread 1 responses back to back
        addRow(makePkt(RD_RSP, 32'h5A00_0210, rndWord()), '0, 0);
        addRow(makePkt(RD_RSP, 32'h5A00_0230, rndWord()), '0, 8);
        addRow(makePkt(RD_RSP, 32'h5A00_0200, rndWord()), '0, 6);
        addRow(makePkt(RD_RSP, 32'h5A00_0220, rndWord()), '0, 6);
        // Back-to-back writes on an idle ring
        addRow('0, makeReq(WR, 2'd0, 32'h5A00_0400, rndWord()), 0);
        addRow('0, makeReq(WR, 2'd1, 32'h5A00_0404, rndWord()), 0);
        addRow('0, makeReq(WR, 2'd2, 32'h5A00_0408, rndWord()), 0);
        addRow('0, makeReq(WR, 2'd3, 32'h5A00_040C, rndWord()), 8);
        // Illegal requests
        addRow('0, makeReq(RD_RSP, 2'd0, 32'h5A00_0500, rndWord()), 1);
        addRow('0, makeReq(WR_BCAST, 2'd1, 32'h5A00_0504, rndWord()), 1);
        addRow('0, makeReq(WR, 2'd2, 32'h0700_0508, rndWord()), 4);
    endtask

    // ====================
    // Clock and limit
    // ====================
    initial begin
        QClk = 1'b0;
        forever #50 QClk = ~QClk;
    end

    always @(posedge QClk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        seed       = 32'hd8e600a1;
        cycles     = 0;
        cycleLimit = 0;
        reset      = 1'b1;
        coreId     = 8'h07;
        ringIn     = '0;
        coreReq    = '0;
        buildTable();
        cycleLimit = tabRing.size() * 20;
        repeat (4) @(posedge QClk);
        reset <= 1'b0;
        for (int r = 0; r < tabRing.size(); r++) begin
            @(posedge QClk);
            ringIn  <= tabRing[r];
            coreReq <= tabReq[r];
            for (int k = 0; k < tabIdle[r]; k++) begin
                @(posedge QClk);
                ringIn  <= '0;
                coreReq <= '0;
            end
        end
        @(posedge QClk);
        ringIn  <= '0;
        coreReq <= '0;
        repeat (4) @(posedge QClk);
        while (!drained) @(posedge QClk);   // Outstanding traffic must finish
        repeat (4) @(posedge QClk);
        $display("Errors: %0d on the ring side, %0d on the core side", ringErrors, coreErrors);
        if (ringErrors + coreErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
